// ==== include/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath widths
`define CPU_WORD_W      32
`define CPU_INSTR_W     16
`define CPU_ADDR_W      12

// register file size
`define CPU_REG_COUNT   16

// instruction queue entries
`define CPU_IBUF_DEPTH  4

// first halfword fetched out of reset
`define CPU_RESET_PC    0

`endif

// ==== src/cpu_pkg.sv ====
`include "cpu_defines.svh"

package cpu_pkg;

  // ******************************
  // vector types
  // ******************************
  typedef logic [`CPU_WORD_W-1:0]               word_t;
  typedef logic [`CPU_INSTR_W-1:0]              instr_t;
  typedef logic [`CPU_ADDR_W-1:0]               mem_addr_t;
  typedef logic [$clog2(`CPU_REG_COUNT)-1:0]    reg_idx_t;
  // n z c v from msb down
  typedef logic [3:0]                           flags_t;

  // top nibble of the instruction
  typedef enum logic [3:0] {
    OP_NOP   = 4'd0,
    OP_MOVI  = 4'd1,
    OP_ADD   = 4'd2,
    OP_ADC   = 4'd3,
    OP_SUB   = 4'd4,
    OP_AND   = 4'd5,
    OP_OR    = 4'd6,
    OP_XOR   = 4'd7,
    OP_STORE = 4'd8
  } opcode_t;

  // fetch FSM, one read in flight at most
  typedef enum logic {
    FETCH_IDLE,
    FETCH_WAIT
  } fetch_state_t;

endpackage

// ==== src/cpu_ifs.sv ====
`timescale 1ns/1ps

// ******************************
// fetch read channel
// ******************************
interface fetch_mem_if;
  logic              rd_req;
  cpu_pkg::mem_addr_t rd_addr;
  logic              rd_grant;
  // one cycle after an accepted read
  logic              rd_valid;
  cpu_pkg::instr_t   rd_data;

  modport fetch (output rd_req, output rd_addr,
                 input rd_grant, input rd_valid, input rd_data);

  modport port (input rd_req, input rd_addr,
                output rd_grant, output rd_valid, output rd_data);
endinterface

// ******************************
// store write channel
// ******************************
interface store_if;
  // held by exec until st_done
  logic               st_req;
  cpu_pkg::mem_addr_t st_addr;
  cpu_pkg::instr_t    st_data;
  logic               st_done;

  modport exec (output st_req, output st_addr, output st_data,
                input st_done);

  modport port (input st_req, input st_addr, input st_data,
                output st_done);
endinterface

// ==== src/alu.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module alu (
  input  cpu_pkg::opcode_t op,
  input  cpu_pkg::word_t   a,
  input  cpu_pkg::word_t   b,
  input  cpu_pkg::flags_t  flags_in,
  output cpu_pkg::word_t   result,
  output cpu_pkg::flags_t  flags_out
);
  import cpu_pkg::*;

  word_t                b_op;
  logic                 c_in;
  logic [`CPU_WORD_W:0] sum;
  logic                 n_flag;
  logic                 z_flag;
  logic                 v_flag;

  // ******************************
  // shared adder
  // ******************************
  // sub as a + ~b + 1 so carry out means no borrow
  assign b_op = (op == OP_SUB) ? ~b : b;

  always_comb begin
    case (op)
      OP_SUB:  c_in = 1'b1;
      OP_ADC:  c_in = flags_in[1];
      default: c_in = 1'b0;
    endcase
  end

  assign sum = {1'b0, a} + {1'b0, b_op} + {{`CPU_WORD_W{1'b0}}, c_in};

  // signed overflow when operands agree in sign and the result does not
  assign v_flag = (a[`CPU_WORD_W-1] == b_op[`CPU_WORD_W-1]) &&
                  (sum[`CPU_WORD_W-1] != a[`CPU_WORD_W-1]);

  always_comb begin
    case (op)
      OP_ADD, OP_ADC, OP_SUB: result = sum[`CPU_WORD_W-1:0];
      OP_AND:                 result = a & b;
      OP_OR:                  result = a | b;
      OP_XOR:                 result = a ^ b;
      default:                result = a;
    endcase
  end

  assign n_flag = result[`CPU_WORD_W-1];
  assign z_flag = (result == '0);

  always_comb begin
    case (op)
      // arithmetic sets all four
      OP_ADD, OP_ADC, OP_SUB: flags_out = {n_flag, z_flag, sum[`CPU_WORD_W], v_flag};
      // logic keeps c and v
      OP_AND, OP_OR, OP_XOR:  flags_out = {n_flag, z_flag, flags_in[1:0]};
      default:                flags_out = flags_in;
    endcase
  end

endmodule

// ==== src/instr_queue.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module instr_queue (
  input  logic            clock,
  input  logic            rst_n,
  input  logic            push,
  input  cpu_pkg::instr_t push_data,
  input  logic            pop,
  output cpu_pkg::instr_t head,
  output logic            empty,
  output logic            full
);
  import cpu_pkg::*;

  localparam int DEPTH = `CPU_IBUF_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  instr_t           mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;
  logic             wr_en;
  logic             rd_en;

  // overflow and underflow are dropped
  assign wr_en = push && !full;
  assign rd_en = pop && !empty;

  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));
  assign head  = mem[rd_ptr];

  // payload storage
  always_ff @(posedge clock) begin
    if (wr_en)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      // simultaneous push and pop keeps count
      if (wr_en && !rd_en)
        count <= count + 1'b1;
      else if (rd_en && !wr_en)
        count <= count - 1'b1;
    end
  end

endmodule

// ==== src/instr_fetch.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module instr_fetch (
  input  logic               clock,
  input  logic               rst_n,
  input  logic               stall_from_instructionfetch,
  input  logic               full,
  fetch_mem_if.fetch         fetch_mem,
  output logic               push,
  output cpu_pkg::instr_t    push_data
);
  import cpu_pkg::*;

  fetch_state_t state;
  mem_addr_t    pc;

  // new requests only when idle, queue has room and no stall
  assign fetch_mem.rd_req  = (state == FETCH_IDLE) && !full && !stall_from_instructionfetch;
  assign fetch_mem.rd_addr = pc;

  // returned halfword goes straight into the queue
  assign push      = (state == FETCH_WAIT) && fetch_mem.rd_valid;
  assign push_data = fetch_mem.rd_data;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state <= FETCH_IDLE;
      pc    <= mem_addr_t'(`CPU_RESET_PC);
    end else begin
      case (state)
        FETCH_IDLE: begin
          // refused grant just retries next cycle
          if (fetch_mem.rd_req && fetch_mem.rd_grant)
            state <= FETCH_WAIT;
        end
        FETCH_WAIT: begin
          // stall does not cancel the read in flight
          if (fetch_mem.rd_valid) begin
            pc    <= pc + 1'b1;
            state <= FETCH_IDLE;
          end
        end
        default: state <= FETCH_IDLE;
      endcase
    end
  end

endmodule

// ==== src/mem_port.sv ====
`timescale 1ns/1ps

module mem_port (
  input  logic               clock,
  input  logic               rst_n,
  input  cpu_pkg::instr_t    mem_rdata,
  fetch_mem_if.port          fetch_mem,
  store_if.port              store,
  output logic               mem_read_enable,
  output logic               mem_write_enable,
  output logic               mem_enable,
  output cpu_pkg::mem_addr_t mem_address,
  output cpu_pkg::instr_t    mem_wdata
);

  logic rd_inflight;

  // ******************************
  // arbitration, stores first
  // ******************************
  assign store.st_done     = store.st_req;
  assign fetch_mem.rd_grant = !store.st_req;

  // external strobes, never both high
  assign mem_write_enable = store.st_req;
  assign mem_read_enable  = fetch_mem.rd_req && fetch_mem.rd_grant;
  assign mem_enable       = mem_read_enable || mem_write_enable;

  assign mem_address = store.st_req ? store.st_addr : fetch_mem.rd_addr;
  assign mem_wdata   = store.st_data;

  // ******************************
  // read return path
  // ******************************
  // memory answers one cycle after read enable
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n)
      rd_inflight <= 1'b0;
    else
      rd_inflight <= mem_read_enable;
  end

  assign fetch_mem.rd_valid = rd_inflight;
  assign fetch_mem.rd_data  = mem_rdata;

endmodule

// ==== src/exec_unit.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module exec_unit (
  input  logic            clock,
  input  logic            rst_n,
  input  cpu_pkg::instr_t head,
  input  logic            empty,
  output logic            pop,
  store_if.exec           store
);
  import cpu_pkg::*;

  word_t    regs [`CPU_REG_COUNT];
  flags_t   flags;
  opcode_t  op;
  reg_idx_t rd;
  reg_idx_t ra;
  reg_idx_t rb;
  word_t    alu_result;
  flags_t   alu_flags;
  logic     is_alu;
  logic     is_movi;
  logic     is_store;
  logic     wr_en;
  word_t    wr_data;

  // ******************************
  // decode of the queue head
  // ******************************
  assign op = opcode_t'(head[15:12]);
  assign rd = head[11:8];
  assign ra = head[7:4];
  assign rb = head[3:0];

  always_comb begin
    is_alu   = 1'b0;
    is_movi  = 1'b0;
    is_store = 1'b0;
    case (op)
      OP_ADD, OP_ADC, OP_SUB, OP_AND, OP_OR, OP_XOR: is_alu = 1'b1;
      OP_MOVI:  is_movi  = 1'b1;
      OP_STORE: is_store = 1'b1;
      // nop and unused codes fall through
      default: ;
    endcase
  end

  alu alu_inst (
    .op        (op),
    .a         (regs[ra]),
    .b         (regs[rb]),
    .flags_in  (flags),
    .result    (alu_result),
    .flags_out (alu_flags)
  );

  // store waits at the head until the port takes it
  assign store.st_req  = !empty && is_store;
  assign store.st_addr = regs[ra][`CPU_ADDR_W-1:0];
  assign store.st_data = regs[rd][`CPU_INSTR_W-1:0];

  // everything else retires in one cycle
  assign pop = !empty && (!is_store || store.st_done);

  // ******************************
  // register file and flags
  // ******************************
  assign wr_en   = !empty && (is_alu || is_movi);
  // movi immediate zero extended
  assign wr_data = is_movi ? word_t'(head[7:0]) : alu_result;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `CPU_REG_COUNT; i++)
        regs[i] <= '0;
      flags <= '0;
    end else begin
      if (wr_en)
        regs[rd] <= wr_data;
      // only alu ops touch nzcv
      if (!empty && is_alu)
        flags <= alu_flags;
    end
  end

endmodule

// ==== src/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core (
  input  logic               clock,
  input  logic               rst_n,
  input  logic               stall_from_instructionfetch,
  input  cpu_pkg::instr_t    mem_rdata,
  output logic               mem_read_enable,
  output logic               mem_write_enable,
  output logic               mem_enable,
  output cpu_pkg::mem_addr_t mem_address,
  output cpu_pkg::instr_t    mem_wdata
);
  import cpu_pkg::*;

  // ******************************
  // internal channels
  // ******************************
  fetch_mem_if fetch_mem ();
  store_if     store ();

  // fetch to queue
  logic   push;
  instr_t push_data;
  logic   full;
  // queue to exec
  instr_t head;
  logic   empty;
  logic   pop;

  // ******************************
  // producer, buffer, consumer
  // ******************************
  instr_fetch instr_fetch_inst (
    .clock                       (clock),
    .rst_n                       (rst_n),
    .stall_from_instructionfetch (stall_from_instructionfetch),
    .full                        (full),
    .fetch_mem                   (fetch_mem.fetch),
    .push                        (push),
    .push_data                   (push_data)
  );

  instr_queue instr_queue_inst (
    .clock     (clock),
    .rst_n     (rst_n),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .head      (head),
    .empty     (empty),
    .full      (full)
  );

  exec_unit exec_unit_inst (
    .clock (clock),
    .rst_n (rst_n),
    .head  (head),
    .empty (empty),
    .pop   (pop),
    .store (store.exec)
  );

  // single external memory port
  mem_port mem_port_inst (
    .clock            (clock),
    .rst_n            (rst_n),
    .mem_rdata        (mem_rdata),
    .fetch_mem        (fetch_mem.port),
    .store            (store.port),
    .mem_read_enable  (mem_read_enable),
    .mem_write_enable (mem_write_enable),
    .mem_enable       (mem_enable),
    .mem_address      (mem_address),
    .mem_wdata        (mem_wdata)
  );

endmodule

// ==== bench/tb_mem_model.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module tb_mem_model (
  input  logic               clock,
  input  logic               read_enable,
  input  logic               write_enable,
  input  logic               enable,
  input  cpu_pkg::mem_addr_t address,
  input  cpu_pkg::instr_t    wdata,
  output cpu_pkg::instr_t    rdata
);
  import cpu_pkg::*;

  localparam int WORDS = 1 << `CPU_ADDR_W;

  // program image seen by the fetch side
  instr_t mem [WORDS];
  // store data lands here, program image stays intact
  instr_t data_mem [WORDS];
  int     write_count;

  // ******************************
  // power-up contents
  // ******************************
  initial begin
    // nop opcode, low 12 bits carry the address
    for (int i = 0; i < WORDS; i++) begin
      mem[i]      = {4'h0, i[`CPU_ADDR_W-1:0]};
      data_mem[i] = '0;
    end
    write_count = 0;
    rdata       = '0;
  end

  // program words from the testbench
  task automatic load_word(input int addr, input instr_t word);
    mem[addr] = word;
  endtask

  // ******************************
  // synchronous port
  // ******************************
  // read data valid one cycle after the enable
  always @(posedge clock) begin
    if (enable && read_enable)
      rdata <= mem[address];
    if (enable && write_enable) begin
      data_mem[address] <= wdata;
      write_count       <= write_count + 1;
    end
  end

endmodule

// ==== bench/tb_cpu_core.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module tb_cpu_core;
  import cpu_pkg::*;

  localparam int PROG_LEN        = 96;
  // far enough past the program that every instruction has retired
  localparam int DONE_ADDR       = PROG_LEN + `CPU_IBUF_DEPTH + 2;
  localparam int WATCHDOG_CYCLES = 40 * PROG_LEN;

  logic      clock;
  logic      rst_n;
  logic      stall_from_instructionfetch;
  instr_t    mem_rdata;
  logic      mem_read_enable;
  logic      mem_write_enable;
  logic      mem_enable;
  mem_addr_t mem_address;
  instr_t    mem_wdata;

  integer    seed = 32'h673e;
  instr_t    prog [PROG_LEN];
  int        prog_cnt;
  // expected stores in program order
  mem_addr_t exp_addr [$];
  instr_t    exp_data [$];
  // last value stored at each address
  instr_t    exp_image [mem_addr_t];
  int        exp_total;
  int        store_cnt;
  int        next_rd_addr;
  logic      run_checks;

  cpu_core i_dut (
    .clock                       (clock),
    .rst_n                       (rst_n),
    .stall_from_instructionfetch (stall_from_instructionfetch),
    .mem_rdata                   (mem_rdata),
    .mem_read_enable             (mem_read_enable),
    .mem_write_enable            (mem_write_enable),
    .mem_enable                  (mem_enable),
    .mem_address                 (mem_address),
    .mem_wdata                   (mem_wdata)
  );

  tb_mem_model i_mem (
    .clock        (clock),
    .read_enable  (mem_read_enable),
    .write_enable (mem_write_enable),
    .enable       (mem_enable),
    .address      (mem_address),
    .wdata        (mem_wdata),
    .rdata        (mem_rdata)
  );

  initial clock = 1'b0;
  always #5 clock = ~clock;

  task automatic report_error(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    $display("Simulation FAILED");
    $fatal(1, "stopping on first error");
  endtask

  task automatic emit(input instr_t ins);
    prog[prog_cnt] = ins;
    prog_cnt++;
  endtask

  // ******************************
  // random program
  // ******************************
  task automatic build_program();
    logic [31:0] r;
    reg_idx_t    rd;
    reg_idx_t    ra;
    reg_idx_t    rb;
    opcode_t     op;
    prog_cnt = 0;
    while (prog_cnt < PROG_LEN - 8) begin
      r  = $random(seed);
      rd = r[7:4];
      ra = r[11:8];
      rb = r[15:12];
      case (r[1:0])
        // immediate straight out to memory
        2'd0: begin
          emit({OP_MOVI, rd, r[23:16]});
          emit({OP_STORE, rd, ra, 4'h0});
        end
        // carry chain with a logic op in between that must keep c
        2'd1: begin
          case (r[20:19])
            2'd0:    op = OP_AND;
            2'd1:    op = OP_OR;
            default: op = OP_XOR;
          endcase
          emit({(r[2] ? OP_SUB : OP_ADD), rd, ra, rb});
          emit({op, rb, ra, rd});
          emit({OP_ADC, rd, rd, ra});
          emit({OP_STORE, rd, rb, 4'h0});
        end
        // any alu op and a store of its result
        2'd2: begin
          case (r[18:16])
            3'd0:    op = OP_ADD;
            3'd1:    op = OP_ADC;
            3'd2:    op = OP_SUB;
            3'd3:    op = OP_AND;
            3'd4:    op = OP_OR;
            default: op = OP_XOR;
          endcase
          emit({op, rd, ra, rb});
          emit({OP_STORE, rd, rb, 4'h0});
        end
        default: begin
          emit({OP_MOVI, rd, r[23:16]});
          emit({OP_MOVI, ra, r[31:24]});
        end
      endcase
    end
    // trailing nops
    while (prog_cnt < PROG_LEN)
      emit(16'h0000);
  endtask

  // ******************************
  // reference model
  // ******************************
  task automatic run_reference();
    logic [31:0] regs [16];
    logic        carry;
    logic [32:0] wide;
    instr_t      ins;
    logic [31:0] a;
    logic [31:0] b;
    for (int i = 0; i < 16; i++)
      regs[i] = '0;
    carry = 1'b0;
    for (int i = 0; i < PROG_LEN; i++) begin
      ins = prog[i];
      a   = regs[ins[7:4]];
      b   = regs[ins[3:0]];
      case (ins[15:12])
        // movi zero extends the byte
        4'd1: regs[ins[11:8]] = {24'h0, ins[7:0]};
        4'd2: begin
          wide             = {1'b0, a} + {1'b0, b};
          regs[ins[11:8]]  = wide[31:0];
          carry            = wide[32];
        end
        4'd3: begin
          wide             = {1'b0, a} + {1'b0, b} + {32'h0, carry};
          regs[ins[11:8]]  = wide[31:0];
          carry            = wide[32];
        end
        // sub sets carry when no borrow
        4'd4: begin
          regs[ins[11:8]]  = a - b;
          carry            = (a >= b);
        end
        4'd5: regs[ins[11:8]] = a & b;
        4'd6: regs[ins[11:8]] = a | b;
        4'd7: regs[ins[11:8]] = a ^ b;
        // store rd low half at address from ra
        4'd8: begin
          exp_addr.push_back(a[`CPU_ADDR_W-1:0]);
          exp_data.push_back(regs[ins[11:8]][15:0]);
          exp_image[a[`CPU_ADDR_W-1:0]] = regs[ins[11:8]][15:0];
        end
        default: ;
      endcase
    end
  endtask

  // final contents of every stored address
  task automatic check_memory_image();
    foreach (exp_image[addr])
      assert (i_mem.data_mem[addr] == exp_image[addr])
        else report_error($sformatf("memory %0h holds %0h, expected %0h",
                                    addr, i_mem.data_mem[addr], exp_image[addr]));
  endtask

  // ******************************
  // port checks
  // ******************************
  always @(posedge clock) begin
    if (run_checks) begin
      assert (!(mem_read_enable && mem_write_enable))
        else report_error("read and write enable high together");
      assert (mem_enable == (mem_read_enable || mem_write_enable))
        else report_error($sformatf("mem_enable is %0b", mem_enable));
      if (stall_from_instructionfetch)
        assert (!mem_read_enable) else report_error("read issued during stall");
      if (mem_read_enable) begin
        assert (mem_address == mem_addr_t'(next_rd_addr))
          else report_error($sformatf("read address %0h, expected %0h",
                                      mem_address, next_rd_addr));
        next_rd_addr <= next_rd_addr + 1;
      end
      if (mem_write_enable) begin
        assert (exp_addr.size() != 0) else report_error("store beyond the expected list");
        assert (mem_address == exp_addr[0] && mem_wdata == exp_data[0])
          else report_error($sformatf("store %0h <- %0h, expected %0h <- %0h",
                                      mem_address, mem_wdata, exp_addr[0], exp_data[0]));
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
        store_cnt <= store_cnt + 1;
      end
    end
  end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("watchdog expired before the program finished");
    $display("Simulation FAILED");
    $fatal(1, "timeout");
  end

  // ******************************
  // main sequence
  // ******************************
  initial begin
    logic [31:0] r;
    rst_n                       = 1'b0;
    stall_from_instructionfetch = 1'b0;
    run_checks                  = 1'b0;
    store_cnt                   = 0;
    next_rd_addr                = `CPU_RESET_PC;
    build_program();
    run_reference();
    exp_total = exp_addr.size();
    @(negedge clock);
    for (int i = 0; i < PROG_LEN; i++)
      i_mem.load_word(i, prog[i]);
    // four clocks of reset in all
    repeat (3) @(negedge clock);
    rst_n      = 1'b1;
    run_checks = 1'b1;
    // random stall until fetch is well past the program
    while (next_rd_addr < DONE_ADDR) begin
      @(negedge clock);
      r = $random(seed);
      stall_from_instructionfetch = (r[1:0] == 2'b00);
    end
    stall_from_instructionfetch = 1'b0;
    @(negedge clock);
    check_memory_image();
    if (store_cnt == exp_total && i_mem.write_count == exp_total &&
        exp_addr.size() == 0) begin
      $display("%0d stores checked", store_cnt);
      $display("Simulation PASSED");
      $finish;
    end else begin
      report_error($sformatf("saw %0d stores, memory recorded %0d, expected %0d",
                             store_cnt, i_mem.write_count, exp_total));
    end
  end

endmodule

// ==== compile.f ====
+incdir+include
src/cpu_pkg.sv
src/cpu_ifs.sv
src/alu.sv
src/instr_queue.sv
src/instr_fetch.sv
src/mem_port.sv
src/exec_unit.sv
src/cpu_core.sv
bench/tb_mem_model.sv
bench/tb_cpu_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpu_core
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# build, run, and pass only if the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep "Simulation PASSED" > /dev/null

clean:
	rm -rf $(BUILD_DIR)
